// ==== switch_settings.svh ====
`ifndef SWITCH_SETTINGS_SVH
`define SWITCH_SETTINGS_SVH

`define SW_NUM_PORTS        4
`define SW_BUFFER_DEPTH     8
`define SW_TOTAL_NODES      16
`define SW_NODE_ID          5
`define SW_PKT_MAX_LENGTH   127

// Flit layout
`define SW_VC_BIT           40
`define SW_ID_MSB           39
`define SW_ID_LSB           36
`define SW_DEST_MSB         35
`define SW_DEST_LSB         32
`define SW_PAYLOAD_MSB      31
`define SW_PAYLOAD_LSB      0
`define SW_FMT_MSB          31  // Relative to payload
`define SW_FMT_LSB          28

`endif

// ==== chiplet_types_pkg.sv ====
`include "switch_settings.svh"

package chiplet_types_pkg;

    // vc | id | dest | payload
    typedef logic [`SW_VC_BIT:0] flit_t;

    typedef logic [$clog2(`SW_TOTAL_NODES)-1:0] node_id_t;
    typedef logic [$clog2(`SW_NUM_PORTS)-1:0]   port_idx_t;
    typedef logic [`SW_NUM_PORTS-1:0]           port_mask_t;

    typedef logic [$clog2(`SW_PKT_MAX_LENGTH + 1)-1:0] pkt_len_t;   // Body flits

    // Head formats, from the top nibble of the payload
    typedef enum logic [`SW_FMT_MSB-`SW_FMT_LSB:0] {
        FMT_SHORT_READ  = 4'h1,
        FMT_SHORT_WRITE = 4'h2,   // Length in payload [3:0]
        FMT_LONG_READ   = 4'h3,
        FMT_LONG_WRITE  = 4'h4    // Length in payload [6:0]
    } fmt_t;

    typedef enum logic [1:0] {
        IDLE,
        HEAD,
        BODY
    } arb_state_t;

endpackage

// ==== buffers_if.sv ====
`timescale 1ns/1ps

`include "switch_settings.svh"

interface buffers_if;
    import chiplet_types_pkg::*;

    logic  [`SW_NUM_PORTS-1:0][1:0] wen;
    logic  [`SW_NUM_PORTS-1:0][1:0] ren;
    flit_t [`SW_NUM_PORTS-1:0]      wdata;  // Shared by both channels of a port
    flit_t [`SW_NUM_PORTS-1:0][1:0] rdata;
    logic  [`SW_NUM_PORTS-1:0][1:0] empty;
    logic  [`SW_NUM_PORTS-1:0][1:0] full;

    modport fifo (
        input  wen, ren, wdata,
        output rdata, empty, full
    );

    modport arb (
        input  rdata, empty,
        output ren
    );

endinterface

// ==== vc_buffers.sv ====
`timescale 1ns/1ps

`include "switch_settings.svh"

module vc_buffers (
    input logic     clk,
    input logic     n_rst,
    buffers_if.fifo buf_if
);
    import chiplet_types_pkg::*;

    localparam int PTR_W = $clog2(`SW_BUFFER_DEPTH);
    localparam int CNT_W = $clog2(`SW_BUFFER_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(`SW_BUFFER_DEPTH - 1);

    flit_t            mem   [`SW_NUM_PORTS][2][`SW_BUFFER_DEPTH];
    logic [PTR_W-1:0] wptr  [`SW_NUM_PORTS][2];
    logic [PTR_W-1:0] rptr  [`SW_NUM_PORTS][2];
    logic [CNT_W-1:0] count [`SW_NUM_PORTS][2];

    always_ff @(posedge clk) begin
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            for (int v = 0; v < 2; v++) begin
                if (buf_if.wen[p][v]) begin
                    mem[p][v][wptr[p][v]] <= buf_if.wdata[p];
                end
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                for (int v = 0; v < 2; v++) begin
                    wptr[p][v]  <= '0;
                    rptr[p][v]  <= '0;
                    count[p][v] <= '0;
                end
            end
        end else begin
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                for (int v = 0; v < 2; v++) begin
                    if (buf_if.wen[p][v]) begin
                        wptr[p][v] <= (wptr[p][v] == PTR_LAST) ? '0 : wptr[p][v] + 1'b1;
                    end
                    if (buf_if.ren[p][v]) begin
                        rptr[p][v] <= (rptr[p][v] == PTR_LAST) ? '0 : rptr[p][v] + 1'b1;
                    end
                    case ({buf_if.wen[p][v], buf_if.ren[p][v]})
                        2'b10:   count[p][v] <= count[p][v] + 1'b1;
                        2'b01:   count[p][v] <= count[p][v] - 1'b1;
                        default: count[p][v] <= count[p][v];  // Both or neither
                    endcase
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            for (int v = 0; v < 2; v++) begin
                buf_if.rdata[p][v] = mem[p][v][rptr[p][v]];   // First-word fall-through
                buf_if.empty[p][v] = (count[p][v] == '0);
                buf_if.full[p][v]  = (count[p][v] == CNT_W'(`SW_BUFFER_DEPTH));
            end
        end
    end

endmodule

// ==== input_arbiter.sv ====
`timescale 1ns/1ps

`include "switch_settings.svh"

module input_arbiter (
    input  logic                                   clk,
    input  logic                                   n_rst,
    buffers_if.arb                                 buf_if,
    output chiplet_types_pkg::flit_t [`SW_NUM_PORTS-1:0] head_flit,
    output chiplet_types_pkg::port_mask_t          head_valid,
    output chiplet_types_pkg::port_mask_t          req,
    output chiplet_types_pkg::port_mask_t          tail,
    output chiplet_types_pkg::flit_t [`SW_NUM_PORTS-1:0] cur_flit,
    input  chiplet_types_pkg::port_mask_t          pop
);
    import chiplet_types_pkg::*;

    localparam int FMT_BASE = `SW_PAYLOAD_LSB;

    arb_state_t                state     [`SW_NUM_PORTS];
    pkt_len_t                  remaining [`SW_NUM_PORTS];
    pkt_len_t                  head_len  [`SW_NUM_PORTS];
    logic [`SW_NUM_PORTS-1:0]  sel_vc;
    logic [`SW_NUM_PORTS-1:0]  last_vc;
    logic [`SW_NUM_PORTS-1:0]  pick_vc;

    always_comb begin
        fmt_t fmt;
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            cur_flit[p] = buf_if.rdata[p][sel_vc[p]];
            fmt = fmt_t'(cur_flit[p][FMT_BASE+`SW_FMT_MSB:FMT_BASE+`SW_FMT_LSB]);
            case (fmt)
                FMT_SHORT_WRITE: head_len[p] = pkt_len_t'(cur_flit[p][FMT_BASE +: 4]);
                FMT_LONG_WRITE:  head_len[p] = cur_flit[p][FMT_BASE +: 7];
                default:         head_len[p] = '0;   // Reads and unknown codes
            endcase

            // Alternate when both channels wait
            if (!buf_if.empty[p][0] && !buf_if.empty[p][1]) begin
                pick_vc[p] = !last_vc[p];
            end else begin
                pick_vc[p] = buf_if.empty[p][0];
            end

            head_valid[p] = (state[p] == HEAD);
            head_flit[p]  = head_valid[p] ? cur_flit[p] : '0;
            // Only while the chosen channel actually holds the next flit
            req[p]  = (state[p] != IDLE) && !buf_if.empty[p][sel_vc[p]];
            tail[p] = ((state[p] == HEAD) && (head_len[p] == '0)) ||
                      ((state[p] == BODY) && (remaining[p] == pkt_len_t'(1)));

            buf_if.ren[p][0] = pop[p] && !sel_vc[p];
            buf_if.ren[p][1] = pop[p] && sel_vc[p];
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            sel_vc  <= '0;
            last_vc <= '1;   // VC 0 wins the first tie
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                state[p]     <= IDLE;
                remaining[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `SW_NUM_PORTS; p++) begin
                case (state[p])
                    IDLE: begin
                        if (!(&buf_if.empty[p])) begin
                            state[p]   <= HEAD;
                            sel_vc[p]  <= pick_vc[p];
                            last_vc[p] <= pick_vc[p];
                        end
                    end
                    HEAD: begin
                        if (pop[p]) begin
                            remaining[p] <= head_len[p];
                            state[p]     <= (head_len[p] == '0) ? IDLE : BODY;
                        end
                    end
                    BODY: begin
                        if (pop[p]) begin
                            remaining[p] <= remaining[p] - 1'b1;
                            if (remaining[p] == pkt_len_t'(1)) begin
                                state[p] <= IDLE;
                            end
                        end
                    end
                    default: state[p] <= IDLE;
                endcase
            end
        end
    end

endmodule

// ==== route_compute.sv ====
`timescale 1ns/1ps

`include "switch_settings.svh"

module route_compute (
    input  logic                                           clk,
    input  logic                                           n_rst,
    input  chiplet_types_pkg::flit_t [`SW_NUM_PORTS-1:0]   head_flit,
    input  chiplet_types_pkg::port_mask_t                  head_valid,
    input  logic                                           cfg_wen,
    input  chiplet_types_pkg::node_id_t                    cfg_node,
    input  chiplet_types_pkg::port_idx_t                   cfg_port,
    output chiplet_types_pkg::port_mask_t [`SW_NUM_PORTS-1:0] out_req
);
    import chiplet_types_pkg::*;

    port_idx_t route_table [`SW_TOTAL_NODES];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int n = 0; n < `SW_TOTAL_NODES; n++) begin
                if (n == `SW_NODE_ID) begin
                    route_table[n] <= '0;   // Local port
                end else begin
                    route_table[n] <= port_idx_t'(n % (`SW_NUM_PORTS - 1) + 1);
                end
            end
        end else if (cfg_wen) begin
            route_table[cfg_node] <= cfg_port;
        end
    end

    // One-hot output request per valid head
    always_comb begin
        node_id_t dest;
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            dest = head_flit[p][`SW_DEST_MSB:`SW_DEST_LSB];
            if (head_valid[p]) begin
                out_req[p] = port_mask_t'(1) << route_table[dest];
            end else begin
                out_req[p] = '0;
            end
        end
    end

endmodule

// ==== switch_allocator.sv ====
`timescale 1ns/1ps

`include "switch_settings.svh"

module switch_allocator (
    input  logic                                              clk,
    input  logic                                              n_rst,
    input  chiplet_types_pkg::port_mask_t [`SW_NUM_PORTS-1:0] out_req,
    input  chiplet_types_pkg::port_mask_t                     req,
    input  chiplet_types_pkg::port_mask_t                     tail,
    input  chiplet_types_pkg::port_mask_t                     out_hold,
    output chiplet_types_pkg::port_mask_t                     pop,
    output chiplet_types_pkg::port_idx_t [`SW_NUM_PORTS-1:0]  sel,
    output chiplet_types_pkg::port_mask_t                     enable
);
    import chiplet_types_pkg::*;

    port_mask_t                    locked;   // Output owned by a packet
    port_idx_t [`SW_NUM_PORTS-1:0] rr_ptr;   // Last input served
    port_idx_t [`SW_NUM_PORTS-1:0] next_in;
    port_mask_t                    found;

    // Nearest requester after the pointer wins, so scan from the far end
    always_comb begin
        port_idx_t cand;
        next_in = rr_ptr;
        found   = '0;
        for (int o = 0; o < `SW_NUM_PORTS; o++) begin
            for (int k = `SW_NUM_PORTS; k >= 1; k--) begin
                cand = port_idx_t'((int'(rr_ptr[o]) + k) % `SW_NUM_PORTS);
                if (req[cand] && out_req[cand][o]) begin
                    next_in[o] = cand;
                    found[o]   = 1'b1;
                end
            end
        end
    end

    always_comb begin
        pop = '0;
        for (int o = 0; o < `SW_NUM_PORTS; o++) begin
            enable[o] = locked[o] && req[sel[o]] && !out_hold[o];
            if (enable[o]) begin
                pop[sel[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            locked <= '0;
            sel    <= '0;
            rr_ptr <= '1;   // Port 0 first
        end else begin
            for (int o = 0; o < `SW_NUM_PORTS; o++) begin
                if (!locked[o]) begin
                    if (found[o]) begin
                        locked[o] <= 1'b1;
                        sel[o]    <= next_in[o];
                        rr_ptr[o] <= next_in[o];
                    end
                end else if (enable[o] && tail[sel[o]]) begin
                    locked[o] <= 1'b0;   // Tail leaves this cycle
                end
            end
        end
    end

endmodule

// ==== crossbar.sv ====
`timescale 1ns/1ps

`include "switch_settings.svh"

module crossbar (
    input  logic                                             clk,
    input  logic                                             n_rst,
    input  chiplet_types_pkg::flit_t [`SW_NUM_PORTS-1:0]     cur_flit,
    input  chiplet_types_pkg::port_idx_t [`SW_NUM_PORTS-1:0] sel,
    input  chiplet_types_pkg::port_mask_t                    enable,
    output chiplet_types_pkg::flit_t [`SW_NUM_PORTS-1:0]     out_flit,
    output chiplet_types_pkg::port_mask_t                    data_ready_out
);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            data_ready_out <= '0;
        end else begin
            data_ready_out <= enable;
        end
    end

    // Flit holds between transfers
    always_ff @(posedge clk) begin
        for (int o = 0; o < `SW_NUM_PORTS; o++) begin
            if (enable[o]) begin
                out_flit[o] <= cur_flit[sel[o]];
            end
        end
    end

endmodule

// ==== switch.sv ====
`timescale 1ns/1ps

`include "switch_settings.svh"

module switch (
    input  logic                                           clk,
    input  logic                                           n_rst,
    input  chiplet_types_pkg::flit_t [`SW_NUM_PORTS-1:0]   in_flit,
    input  chiplet_types_pkg::port_mask_t                  data_ready_in,
    output logic [`SW_NUM_PORTS-1:0][1:0]                  buffer_available,
    input  chiplet_types_pkg::port_mask_t                  out_hold,
    input  logic                                           cfg_wen,
    input  chiplet_types_pkg::node_id_t                    cfg_node,
    input  chiplet_types_pkg::port_idx_t                   cfg_port,
    output chiplet_types_pkg::flit_t [`SW_NUM_PORTS-1:0]   out_flit,
    output chiplet_types_pkg::port_mask_t                  data_ready_out
);
    import chiplet_types_pkg::*;

    flit_t      [`SW_NUM_PORTS-1:0] head_flit;
    flit_t      [`SW_NUM_PORTS-1:0] cur_flit;
    port_mask_t [`SW_NUM_PORTS-1:0] out_req;
    port_idx_t  [`SW_NUM_PORTS-1:0] sel;
    port_mask_t head_valid;
    port_mask_t req;
    port_mask_t tail;
    port_mask_t pop;
    port_mask_t enable;

    buffers_if buf_if ();

    assign buf_if.wdata     = in_flit;
    assign buffer_available = ~buf_if.full;

    // Steer each strobe to the channel named in the flit
    always_comb begin
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            buf_if.wen[p][0] = data_ready_in[p] && !in_flit[p][`SW_VC_BIT];
            buf_if.wen[p][1] = data_ready_in[p] && in_flit[p][`SW_VC_BIT];
        end
    end

    vc_buffers u_buffers (
        .clk    (clk),
        .n_rst  (n_rst),
        .buf_if (buf_if.fifo)
    );

    input_arbiter u_arbiter (
        .clk        (clk),
        .n_rst      (n_rst),
        .buf_if     (buf_if.arb),
        .head_flit  (head_flit),
        .head_valid (head_valid),
        .req        (req),
        .tail       (tail),
        .cur_flit   (cur_flit),
        .pop        (pop)
    );

    route_compute u_route (
        .clk        (clk),
        .n_rst      (n_rst),
        .head_flit  (head_flit),
        .head_valid (head_valid),
        .cfg_wen    (cfg_wen),
        .cfg_node   (cfg_node),
        .cfg_port   (cfg_port),
        .out_req    (out_req)
    );

    switch_allocator u_alloc (
        .clk      (clk),
        .n_rst    (n_rst),
        .out_req  (out_req),
        .req      (req),
        .tail     (tail),
        .out_hold (out_hold),
        .pop      (pop),
        .sel      (sel),
        .enable   (enable)
    );

    crossbar u_crossbar (
        .clk            (clk),
        .n_rst          (n_rst),
        .cur_flit       (cur_flit),
        .sel            (sel),
        .enable         (enable),
        .out_flit       (out_flit),
        .data_ready_out (data_ready_out)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

// ==== switch_sva.sv ====
`timescale 1ns/1ps

`include "switch_settings.svh"

module switch_sva (
    input logic                                         clk,
    input logic                                         n_rst,
    input chiplet_types_pkg::flit_t [`SW_NUM_PORTS-1:0] in_flit,
    input chiplet_types_pkg::port_mask_t                data_ready_in,
    input logic [`SW_NUM_PORTS-1:0][1:0]                buffer_available,
    input chiplet_types_pkg::port_mask_t                out_hold,
    input chiplet_types_pkg::port_mask_t                data_ready_out
);
    import chiplet_types_pkg::*;

    port_mask_t                    write_blocked;
    logic [`SW_NUM_PORTS-1:0][1:0] written;
    logic       full_write_seen = 1'b0;
    logic       held_out_seen   = 1'b0;
    logic       early_full_seen = 1'b0;
    logic       any_fail;

    assign any_fail = full_write_seen | held_out_seen | early_full_seen;

    // Strobe into the channel named by the flit while it is full
    always_comb begin
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            write_blocked[p] = data_ready_in[p] && !buffer_available[p][in_flit[p][`SW_VC_BIT]];
        end
    end

    always_comb begin
        for (int p = 0; p < `SW_NUM_PORTS; p++) begin
            written[p][0] = data_ready_in[p] && !in_flit[p][`SW_VC_BIT];
            written[p][1] = data_ready_in[p] && in_flit[p][`SW_VC_BIT];
        end
    end

    a_no_full_write: assert property (@(posedge clk) disable iff (!n_rst)
        write_blocked == '0)
        else begin
            $error("Flit written into a full FIFO");
            full_write_seen = 1'b1;
        end

    a_hold_blocks_output: assert property (@(posedge clk) disable iff (!n_rst)
        (data_ready_out & $past(out_hold)) == '0)
        else begin
            $error("Flit left an output that was held");
            held_out_seen = 1'b1;
        end

    // A channel only fills on a cycle that wrote into it
    a_full_after_write: assert property (@(posedge clk) disable iff (!n_rst)
        (~buffer_available & $past(buffer_available & ~written)) == '0)
        else begin
            $error("buffer_available fell without a write into that channel");
            early_full_seen = 1'b1;
        end

endmodule

// ==== switch_tb.sv ====
`timescale 1ns/1ps

`include "switch_settings.svh"

module switch_tb;
    import chiplet_types_pkg::*;

    localparam int NP              = `SW_NUM_PORTS;
    localparam int EXP_DEPTH       = 256;
    localparam int TEST_FLITS      = 54;
    localparam int WATCHDOG_CYCLES = 200 * TEST_FLITS + 1000;

    logic               clk;
    logic               n_rst;
    flit_t [NP-1:0]     in_flit;
    port_mask_t         data_ready_in;
    logic [NP-1:0][1:0] buffer_available;
    port_mask_t         out_hold;
    logic               cfg_wen;
    node_id_t           cfg_node;
    port_idx_t          cfg_port;
    flit_t [NP-1:0]     out_flit;
    port_mask_t         data_ready_out;

    // Expected flits per output and source input
    flit_t     exp_mem  [NP][NP][EXP_DEPTH];
    int        exp_wr   [NP][NP];
    int        exp_rd   [NP][NP];
    int        pkt_left [NP];   // Flits still due in the packet on an output
    int        cur_src  [NP];
    port_idx_t tb_route [`SW_TOTAL_NODES];
    string     test_name = "reset";

    tb_clock #(.PERIOD_NS(100.0)) u_clock (.clk(clk));

    switch UUT (
        .clk(clk), .n_rst(n_rst), .in_flit(in_flit), .data_ready_in(data_ready_in),
        .buffer_available(buffer_available), .out_hold(out_hold), .cfg_wen(cfg_wen),
        .cfg_node(cfg_node), .cfg_port(cfg_port), .out_flit(out_flit),
        .data_ready_out(data_ready_out)
    );

    bind switch switch_sva u_sva (
        .clk(clk), .n_rst(n_rst), .in_flit(in_flit), .data_ready_in(data_ready_in),
        .buffer_available(buffer_available), .out_hold(out_hold),
        .data_ready_out(data_ready_out)
    );

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_flit(input flit_t expected, input flit_t actual);
        if (actual !== expected) begin
            report_fail($sformatf("MISMATCH %s: expected %h, actual %h",
                                  test_name, expected, actual));
        end
    endtask

    task automatic check_mask(input port_mask_t expected, input port_mask_t actual);
        if (actual !== expected) begin
            report_fail($sformatf("MISMATCH %s: expected %b, actual %b",
                                  test_name, expected, actual));
        end
    endtask

    // Body flits that follow a head, by its format
    function automatic int body_len(input flit_t f);
        case (fmt_t'(f[`SW_FMT_MSB:`SW_FMT_LSB]))
            FMT_SHORT_WRITE: return int'(f[3:0]);
            FMT_LONG_WRITE:  return int'(f[6:0]);
            default:         return 0;
        endcase
    endfunction

    function automatic port_mask_t avail_column(input int vc);
        port_mask_t m;
        for (int p = 0; p < NP; p++) begin
            m[p] = buffer_available[p][vc];
        end
        return m;
    endfunction

    function automatic int find_source(input int o, input flit_t f);
        for (int i = 0; i < NP; i++) begin
            if (exp_rd[o][i] != exp_wr[o][i] && exp_mem[o][i][exp_rd[o][i]] === f) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic bit drained();
        for (int o = 0; o < NP; o++) begin
            if (pkt_left[o] != 0) begin
                return 1'b0;
            end
            for (int i = 0; i < NP; i++) begin
                if (exp_rd[o][i] != exp_wr[o][i]) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    // A head picks the input stream; the rest of the packet must follow from it
    task automatic take_flit(input int o, input flit_t f);
        int src;
        if (pkt_left[o] == 0) begin
            cur_src[o]  = find_source(o, f);
            pkt_left[o] = 1 + body_len(f);
        end
        src = cur_src[o];
        if (src < 0) begin
            report_fail($sformatf("Unexpected head flit %h on output %0d in test %s",
                                  f, o, test_name));
        end else if (exp_rd[o][src] == exp_wr[o][src]) begin
            report_fail($sformatf("Extra flit %h on output %0d in test %s", f, o, test_name));
        end else begin
            check_flit(exp_mem[o][src][exp_rd[o][src]], f);
            exp_rd[o][src]++;
            pkt_left[o]--;
        end
    endtask

    always @(negedge clk) begin
        if (n_rst) begin
            for (int o = 0; o < NP; o++) begin
                if (data_ready_out[o]) begin
                    take_flit(o, out_flit[o]);
                end
            end
        end
    end

    task automatic send_packet(input int port, input bit vc, input node_id_t dest,
                               input fmt_t fmt, input int body, input int tag);
        flit_t f;
        int    o;
        o = tb_route[dest];
        for (int k = 0; k <= body; k++) begin
            if (k == 0) begin
                f = {vc, 4'(tag), dest, fmt, 12'(tag), 16'(body)};
            end else begin
                f = {vc, 4'(tag), dest, 4'hB, 28'($urandom)};
            end
            @(posedge clk);
            #10;
            data_ready_in[port] = 1'b0;
            while (!buffer_available[port][vc]) begin
                @(posedge clk);
                #10;
            end
            in_flit[port]       = f;
            data_ready_in[port] = 1'b1;
            exp_mem[o][port][exp_wr[o][port]] = f;
            exp_wr[o][port]++;
        end
        @(posedge clk);
        #10;
        data_ready_in[port] = 1'b0;
    endtask

    task automatic write_route(input node_id_t node, input port_idx_t port);
        @(posedge clk);
        #10;
        cfg_wen        = 1'b1;
        cfg_node       = node;
        cfg_port       = port;
        tb_route[node] = port;
        @(posedge clk);
        #10;
        cfg_wen = 1'b0;
    endtask

    task automatic wait_drain();
        while (!drained()) begin
            @(posedge clk);
        end
        @(posedge clk);
        #10;
        check_mask('0, data_ready_out);
    endtask

    task automatic test_reset();
        test_name = "reset";
        check_mask('0, data_ready_out);
        check_mask('1, avail_column(0));
        check_mask('1, avail_column(1));
    endtask

    task automatic test_single_flits();
        test_name = "single_flits";
        send_packet(1, 1'b0, 4'd5, FMT_SHORT_READ, 0, 1);   // Local port
        send_packet(1, 1'b1, 4'd6, FMT_SHORT_READ, 0, 2);
        wait_drain();
    endtask

    task automatic test_long_packet();
        test_name = "long_packet";
        send_packet(2, 1'b1, 4'd9, FMT_LONG_WRITE, 20, 3);
        send_packet(1, 1'b0, 4'd10, FMT_SHORT_WRITE, 3, 4);
        send_packet(1, 1'b1, 4'd11, FMT_SHORT_WRITE, 2, 5);
        send_packet(1, 1'b0, 4'd4, FMT_LONG_READ, 0, 6);
        wait_drain();
    endtask

    task automatic test_shared_output();
        test_name = "shared_output";
        fork
            send_packet(1, 1'b0, 4'd12, FMT_SHORT_WRITE, 5, 7);
            send_packet(2, 1'b1, 4'd12, FMT_SHORT_WRITE, 5, 8);
        join
        wait_drain();
    endtask

    task automatic test_hold();
        test_name = "hold";
        @(posedge clk);
        #10;
        out_hold[2] = 1'b1;
        for (int k = 0; k < `SW_BUFFER_DEPTH; k++) begin
            send_packet(3, 1'b0, 4'd7, FMT_SHORT_READ, 0, 9 + k);
            check_mask('0, data_ready_out);
        end
        check_mask(4'b0111, avail_column(0));   // Port 3 channel 0 full
        out_hold[2] = 1'b0;
        wait_drain();
    endtask

    task automatic test_route_write();
        test_name = "route_write";
        write_route(4'd6, 2'd3);
        send_packet(0, 1'b0, 4'd6, FMT_SHORT_WRITE, 1, 3);
        send_packet(0, 1'b1, 4'd13, FMT_SHORT_READ, 0, 4);
        wait_drain();
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_fail($sformatf("Timeout after %0d cycles in test %s", WATCHDOG_CYCLES, test_name));
    end

    initial begin
        wait (UUT.u_sva.any_fail === 1'b1);
        report_fail($sformatf("Assertion failure on the DUT in test %s", test_name));
    end

    initial begin
        void'($urandom(83578));
        n_rst         = 1'b0;
        in_flit       = '0;
        data_ready_in = '0;
        out_hold      = '0;
        cfg_wen       = 1'b0;
        cfg_node      = '0;
        cfg_port      = '0;
        for (int o = 0; o < NP; o++) begin
            pkt_left[o] = 0;
            cur_src[o]  = -1;
            for (int i = 0; i < NP; i++) begin
                exp_wr[o][i] = 0;
                exp_rd[o][i] = 0;
            end
        end
        for (int n = 0; n < `SW_TOTAL_NODES; n++) begin
            tb_route[n] = (n == `SW_NODE_ID) ? port_idx_t'(0) : port_idx_t'(n % (NP - 1) + 1);
        end
        repeat (2) @(posedge clk);
        #10;
        n_rst = 1'b1;

        test_reset();
        test_single_flits();
        test_long_packet();
        test_shared_output();
        test_hold();
        test_route_write();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== switch.f ====
+incdir+.
chiplet_types_pkg.sv
buffers_if.sv
vc_buffers.sv
input_arbiter.sv
route_compute.sv
switch_allocator.sv
crossbar.sv
switch.sv
tb_clock.sv
switch_sva.sv
switch_tb.sv

// ==== Bender.yml ====
package:
  name: chiplet_switch

sources:
  - include_dirs:
      - .
    files:
      - chiplet_types_pkg.sv
      - buffers_if.sv
      - vc_buffers.sv
      - input_arbiter.sv
      - route_compute.sv
      - switch_allocator.sv
      - crossbar.sv
      - switch.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock.sv
      - switch_sva.sv
      - switch_tb.sv
